// ==== Makefile ====
# Verilator build and run of the determinant testbench

TOP       ?= tb_determinant
SEED      ?= 26230
VERILATOR ?= verilator

FILELIST  := determinant.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# exit status of the simulation binary is the result
sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== common/det_defines.svh ====
// widths, multiplier latency and slave register map of the determinant core, include where used
`ifndef DET_DEFINES_SVH
`define DET_DEFINES_SVH

// datapath widths
`define DET_DATA_W 32       // one matrix word
`define DET_BUS_AW 30       // master byte address
`define DET_RAM_AW 10       // row*32 + col
`define DET_MAX_SIZE 32     // largest N
`define DET_SIZE_W 6        // holds 0..32

`define DET_MUL_LATENCY 5   // cycles through the multiplier

// slave offsets, writes and reads share the one address bit
`define DET_REG_PTR 0       // write: source pointer
`define DET_REG_SIZE 1      // write: size, starts a job
`define DET_REG_RESULT 0    // read: determinant
`define DET_REG_STATUS 1    // read: ready / busy

`define DET_STATUS_READY 0
`define DET_STATUS_BUSY 1

`endif

// ==== common/det_pkg.sv ====
// shared vector types and structs of the determinant core, imported by the RTL and the testbench
`default_nettype none

`include "det_defines.svh"

package det_pkg;

	//////////////////////
	// plain vectors

	typedef logic [`DET_DATA_W-1:0] data_t;      // matrix word or running product
	typedef logic [`DET_BUS_AW-1:0] bus_addr_t;  // byte address on the master
	typedef logic [`DET_RAM_AW-1:0] ram_addr_t;  // word address into matrix ram
	typedef logic [`DET_SIZE_W-1:0] mx_size_t;   // size, row or col index

	//////////////////////
	// bundles

	// job handed from the slave to the dma, stable while busy
	typedef struct packed {
		bus_addr_t ptr;
		mx_size_t  size;
	} job_t;

	typedef struct packed {
		logic      we;
		ram_addr_t addr;   // row*32 + col
		data_t     data;
	} ram_wr_t;

	typedef struct packed {
		data_t value;
		logic  singular;   // zero found on the diagonal
	} det_result_t;

endpackage

`default_nettype wire

// ==== determinant.f ====
+incdir+common
common/det_pkg.sv
src/det_csr.sv
dma/det_dma.sv
src/matrix_ram.sv
diag/det_diag.sv
src/determinant.sv
test/avalon_mem_model.sv
test/tb_determinant.sv

// ==== diag/det_diag.sv ====
// diagonal unit of the determinant core: multiplies the diagonal of the stored triangular matrix
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module det_diag import det_pkg::*; (
	input  wire             i_clk,
	input  wire             i_reset,
	input  wire             i_calc_req,
	input  wire mx_size_t   i_size,
	output logic            o_calc_ack,
	output ram_addr_t       o_rd_addr,
	input  wire data_t      i_rd_data,
	output det_result_t     o_result
);

	localparam int LAT   = `DET_MUL_LATENCY;
	localparam int LAT_W = $clog2(LAT);

	typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_MUL, ST_ACK} state_t;
	state_t state;

	mx_size_t         k;                    // diagonal index
	logic [LAT_W-1:0] lat_cnt;              // cycles spent in the multiplier
	data_t            prod;                 // running product, last pipe stage
	data_t            mul_pipe [0:LAT-2];
	det_result_t      result_q;
	logic             lat_done;
	logic             last_k;
	logic             zero_entry;

	// entry (k,k) sits at k*32 + k
	assign o_rd_addr = ram_addr_t'({k[4:0], k[4:0]});

	assign lat_done   = (lat_cnt == LAT_W'(LAT - 1));
	assign last_k     = (k == i_size - mx_size_t'(1));
	// ram data is valid in the first multiply cycle
	assign zero_entry = (state == ST_MUL) && (lat_cnt == '0) && (i_rd_data == '0);

	assign o_result = result_q;

	//////////////////////
	// sweep control

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state      <= ST_IDLE;
			k          <= '0;
			lat_cnt    <= '0;
			o_calc_ack <= 1'b0;
			result_q   <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (i_calc_req) begin
						k     <= '0;
						state <= ST_READ;
					end
				end
				ST_READ: begin
					lat_cnt <= '0;             // address out, data next cycle
					state   <= ST_MUL;
				end
				ST_MUL: begin
					lat_cnt <= lat_cnt + LAT_W'(1);
					if (zero_entry) begin
						// singular, no point in finishing the sweep
						result_q   <= '{value: '0, singular: 1'b1};
						o_calc_ack <= 1'b1;
						state      <= ST_ACK;
					end else if (lat_done) begin
						if (last_k) begin
							result_q   <= '{value: mul_pipe[LAT-2], singular: 1'b0};
							o_calc_ack <= 1'b1;
							state      <= ST_ACK;
						end else begin
							k     <= k + mx_size_t'(1);
							state <= ST_READ;
						end
					end
				end
				ST_ACK: begin
					// result stays put until the next request
					if (!i_calc_req) begin
						o_calc_ack <= 1'b0;
						state      <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////
	// multiplier pipeline

	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE)
			prod <= data_t'(1);                  // empty product
		else if (state == ST_MUL && lat_done)
			prod <= mul_pipe[LAT-2];             // lands in time for the next entry
		if (state == ST_MUL) begin
			// low word is the same for signed operands, wraps
			mul_pipe[0] <= prod * i_rd_data;
			for (int i = 1; i < LAT - 1; i++)
				mul_pipe[i] <= mul_pipe[i-1];
		end
	end

endmodule

`default_nettype wire

// ==== dma/det_dma.sv ====
// burst read master of the determinant core: fills the matrix ram, then hands the job to the diagonal unit
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module det_dma import det_pkg::*; (
	input  wire             i_clk,
	input  wire             i_reset,
	input  wire             i_job_req,
	input  wire job_t       i_job,
	output logic            o_job_ack,
	output bus_addr_t       o_address,
	output logic            o_read,
	input  wire             i_waitrequest,
	input  wire data_t      i_readdata,
	input  wire             i_readdatavalid,
	output ram_wr_t         o_ram_wr,
	output logic            o_calc_req,
	output mx_size_t        o_calc_size,
	input  wire             i_calc_ack
);

	localparam int CNT_W = 2 * `DET_SIZE_W - 1;   // n*n up to 1024

	typedef enum logic [1:0] {ST_IDLE, ST_FETCH, ST_CALC, ST_ACK} state_t;
	state_t state;

	logic [CNT_W-1:0] total;     // words in the matrix
	logic [CNT_W-1:0] req_cnt;   // addresses accepted
	logic [CNT_W-1:0] rcv_cnt;   // words returned
	mx_size_t         row;
	mx_size_t         col;
	logic             wr_we;
	ram_addr_t        wr_addr;
	data_t            wr_data;
	logic             accept;
	logic             beat;
	logic             last_beat;

	assign total     = CNT_W'(i_job.size) * CNT_W'(i_job.size);
	assign accept    = o_read && !i_waitrequest;            // address taken this cycle
	assign beat      = (state == ST_FETCH) && i_readdatavalid;
	assign last_beat = beat && (rcv_cnt == total - CNT_W'(1));

	assign o_calc_size = i_job.size;   // csr holds job until job_ack
	assign o_ram_wr    = '{we: wr_we, addr: wr_addr, data: wr_data};

	//////////////////////
	// control

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state      <= ST_IDLE;
			o_read     <= 1'b0;
			o_calc_req <= 1'b0;
			o_job_ack  <= 1'b0;
			wr_we      <= 1'b0;
			req_cnt    <= '0;
			rcv_cnt    <= '0;
			row        <= '0;
			col        <= '0;
		end else begin
			wr_we <= beat;   // ram write one cycle after the data
			case (state)
				ST_IDLE: begin
					if (i_job_req) begin
						o_read  <= 1'b1;
						req_cnt <= '0;
						rcv_cnt <= '0;
						row     <= '0;
						col     <= '0;
						state   <= ST_FETCH;
					end
				end
				ST_FETCH: begin
					// request side runs ahead of the receive side
					if (accept) begin
						req_cnt <= req_cnt + CNT_W'(1);
						if (req_cnt == total - CNT_W'(1))
							o_read <= 1'b0;    // last address accepted
					end
					if (beat) begin
						rcv_cnt <= rcv_cnt + CNT_W'(1);
						if (col == i_job.size - mx_size_t'(1)) begin
							col <= '0;
							row <= row + mx_size_t'(1);
						end else begin
							col <= col + mx_size_t'(1);
						end
					end
					if (last_beat) begin
						o_calc_req <= 1'b1;    // ram write lands before diag reads
						state      <= ST_CALC;
					end
				end
				ST_CALC: begin
					if (i_calc_ack) begin
						o_calc_req <= 1'b0;
						o_job_ack  <= 1'b1;
						state      <= ST_ACK;
					end
				end
				ST_ACK: begin
					if (!i_job_req) begin     // csr has latched the result
						o_job_ack <= 1'b0;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	//////////////////////
	// address and ram payload

	always_ff @(posedge i_clk) begin
		if (state == ST_IDLE && i_job_req)
			o_address <= i_job.ptr;
		else if (accept)
			o_address <= o_address + bus_addr_t'(4);   // next word, held under waitrequest
		wr_addr <= ram_addr_t'({row[4:0], col[4:0]});     // row*32 + col
		wr_data <= i_readdata;
	end

endmodule

`default_nettype wire

// ==== src/det_csr.sv ====
// register slave of the determinant core: pointer and size writes, job request, result and irq
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module det_csr import det_pkg::*; (
	input  wire               i_clk,
	input  wire               i_reset,
	input  wire               i_slave_address,
	input  wire               i_slave_write,
	input  wire data_t        i_slave_writedata,
	input  wire               i_slave_read,
	output data_t             o_slave_readdata,
	output logic              o_irq,
	output logic              o_job_req,
	output job_t              o_job,
	input  wire               i_job_ack,
	input  wire det_result_t  i_result
);

	bus_addr_t ptr_q;
	mx_size_t  size_q;
	logic      busy;       // job in flight
	data_t     result_q;   // last finished job
	logic      size_wr;
	logic      job_done;

	assign size_wr  = i_slave_write && (i_slave_address == 1'(`DET_REG_SIZE));
	assign job_done = busy && o_job_req && i_job_ack;   // dma acked, job over

	assign o_job = '{ptr: ptr_q, size: size_q};

	//////////////////////
	// pointer and size, frozen while busy

	always_ff @(posedge i_clk) begin
		if (i_slave_write && !busy) begin
			if (i_slave_address == 1'(`DET_REG_PTR))
				ptr_q <= bus_addr_t'(i_slave_writedata);
			else
				size_q <= mx_size_t'(i_slave_writedata);
		end
	end

	//////////////////////
	// job control and interrupt

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			busy      <= 1'b0;
			o_job_req <= 1'b0;
			o_irq     <= 1'b0;
			result_q  <= '0;
		end else begin
			if (i_slave_read)
				o_irq <= 1'b0;                 // any read clears it
			if (size_wr && !busy && (mx_size_t'(i_slave_writedata) != '0)) begin
				busy      <= 1'b1;             // size 0 never starts
				o_job_req <= 1'b1;
			end else if (job_done) begin
				busy      <= 1'b0;
				o_job_req <= 1'b0;             // four-phase: dma drops ack next
				o_irq     <= 1'b1;             // set wins over a same-cycle read
				// singular reads back as zero
				result_q  <= i_result.singular ? '0 : i_result.value;
			end
		end
	end

	// read mux, completes in the same cycle
	always_comb begin
		case (i_slave_address)
			1'(`DET_REG_RESULT): o_slave_readdata = result_q;
			1'(`DET_REG_STATUS): begin
				o_slave_readdata = busy ? data_t'(`DET_STATUS_BUSY)
				                        : data_t'(`DET_STATUS_READY);
			end
			default: o_slave_readdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/determinant.sv ====
// top level of the determinant core: register slave, read master, matrix ram and diagonal unit
`timescale 1ns/1ps
`default_nettype none

module determinant import det_pkg::*; (
	input  wire             i_clk,
	input  wire             i_reset,
	// register slave
	input  wire             i_slave_address,
	input  wire             i_slave_write,
	input  wire data_t      i_slave_writedata,
	input  wire             i_slave_read,
	output data_t           o_slave_readdata,
	output logic            o_irq,
	// read master
	output bus_addr_t       o_address,
	output logic            o_read,
	input  wire             i_waitrequest,
	input  wire data_t      i_readdata,
	input  wire             i_readdatavalid
);

	// csr <-> dma
	logic        job_req;
	job_t        job;
	logic        job_ack;
	// dma <-> diag
	logic        calc_req;
	mx_size_t    calc_size;
	logic        calc_ack;
	det_result_t result;
	// ram ports
	ram_wr_t     ram_wr;
	ram_addr_t   rd_addr;
	data_t       rd_data;

	det_csr u_csr (
		.i_clk             (i_clk),
		.i_reset           (i_reset),
		.i_slave_address   (i_slave_address),
		.i_slave_write     (i_slave_write),
		.i_slave_writedata (i_slave_writedata),
		.i_slave_read      (i_slave_read),
		.o_slave_readdata  (o_slave_readdata),
		.o_irq             (o_irq),
		.o_job_req         (job_req),
		.o_job             (job),
		.i_job_ack         (job_ack),
		.i_result          (result)
	);

	det_dma u_dma (
		.i_clk           (i_clk),
		.i_reset         (i_reset),
		.i_job_req       (job_req),
		.i_job           (job),
		.o_job_ack       (job_ack),
		.o_address       (o_address),
		.o_read          (o_read),
		.i_waitrequest   (i_waitrequest),
		.i_readdata      (i_readdata),
		.i_readdatavalid (i_readdatavalid),
		.o_ram_wr        (ram_wr),
		.o_calc_req      (calc_req),
		.o_calc_size     (calc_size),
		.i_calc_ack      (calc_ack)
	);

	matrix_ram u_ram (
		.i_clk     (i_clk),
		.i_wr      (ram_wr),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_data)
	);

	det_diag u_diag (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_calc_req (calc_req),
		.i_size     (calc_size),
		.o_calc_ack (calc_ack),
		.o_rd_addr  (rd_addr),
		.i_rd_data  (rd_data),
		.o_result   (result)
	);

endmodule

`default_nettype wire

// ==== src/matrix_ram.sv ====
// on-chip matrix store, one write port from the dma and one registered read port for the diagonal unit
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module matrix_ram import det_pkg::*; (
	input  wire            i_clk,
	input  wire ram_wr_t   i_wr,
	input  wire ram_addr_t i_rd_addr,
	output data_t          o_rd_data
);

	// rows at a fixed 32-word stride
	localparam int DEPTH = `DET_MAX_SIZE * `DET_MAX_SIZE;

	data_t mem [0:DEPTH-1];

	//////////////////////
	// write port

	always_ff @(posedge i_clk) begin
		if (i_wr.we)
			mem[i_wr.addr] <= i_wr.data;
	end

	//////////////////////
	// read port

	// data valid one cycle after the address
	always_ff @(posedge i_clk) begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// ==== test/avalon_mem_model.sv ====
// avalon read slave model for the testbench, random waitrequest and in-order data 1 to 3 cycles late
`timescale 1ns/1ps
`default_nettype none

module avalon_mem_model import det_pkg::*; #(
	parameter int SEED = 26230
) (
	input  wire            i_clk,
	input  wire bus_addr_t i_address,
	input  wire            i_read,
	output logic           o_waitrequest,
	output data_t          o_readdata,
	output logic           o_readdatavalid
);

	localparam int WORDS = 4096;

	data_t       mem [0:WORDS-1];
	data_t       q_data [$];        // accepted reads, oldest first
	int          q_due [$];         // cycle in which each may come back
	int          cyc = 0;
	integer      seed = SEED;
	logic        wait_q = 1'b1;     // busy until the first draw
	logic        valid_q = 1'b0;
	data_t       data_q = '0;
	logic [31:0] rnd;
	int          lat;

	assign o_waitrequest   = wait_q;
	assign o_readdata      = data_q;
	assign o_readdatavalid = valid_q;

	// backdoor load, called from the testbench
	task automatic write_word(input int idx, input data_t value);
		mem[idx % WORDS] = value;
	endtask

	//////////////////////
	// everything moves on the falling edge

	always @(negedge i_clk) begin
		cyc = cyc + 1;
		// return side, one word per cycle, in order
		if (q_due.size() != 0 && q_due[0] <= cyc) begin
			valid_q = 1'b1;
			data_q  = q_data[0];
			q_data.delete(0);
			q_due.delete(0);
		end else begin
			valid_q = 1'b0;
			data_q  = '0;
		end
		rnd    = $random(seed);
		wait_q = rnd[0];                        // about half the cycles stalled
		lat    = 1 + int'(rnd[9:8] % 2'd3);
		// read and address hold until the next rising edge, so this is that edge's accept
		if (i_read && !wait_q) begin
			q_data.push_back(mem[i_address[13:2]]);
			q_due.push_back(cyc + lat);
		end
	end

endmodule

`default_nettype wire

// ==== test/tb_determinant.sv ====
// testbench of the determinant core that loads triangular matrices into the memory model and checks each job
`timescale 1ns/1ps
`default_nettype none

`include "det_defines.svh"

module tb_determinant import det_pkg::*; #(
	parameter int SEED = 26230
);

	localparam int   TIMEOUT   = 20000;    // cycles allowed for one job
	localparam int   NUM_CASES = 6;
	localparam int   QUIET     = 300;      // cycles watched for a stray irq
	localparam logic A_PTR     = 1'(`DET_REG_PTR);
	localparam logic A_SIZE    = 1'(`DET_REG_SIZE);
	localparam logic A_RESULT  = 1'(`DET_REG_RESULT);
	localparam logic A_STATUS  = 1'(`DET_REG_STATUS);
	localparam data_t READY    = data_t'(`DET_STATUS_READY);
	localparam data_t BUSY     = data_t'(`DET_STATUS_BUSY);

	typedef struct packed {
		bus_addr_t  ptr;
		mx_size_t   size;
		data_t      base;     // diagonal k holds base + k*step
		data_t      step;
		logic [7:0] zero_k;   // ff when no zero entry
		logic       poke;     // write ptr and size while busy
	} case_t;

	logic      clk = 1'b0;
	logic      reset;
	logic      slave_address;
	logic      slave_write;
	data_t     slave_writedata;
	logic      slave_read;
	data_t     slave_readdata;
	logic      irq;
	bus_addr_t mem_address;
	logic      mem_read;
	logic      mem_waitrequest;
	data_t     mem_readdata;
	logic      mem_readdatavalid;
	case_t     cases [0:NUM_CASES-1];
	integer    seed = SEED;
	int        accepts = 0;         // reads taken in the current job
	bus_addr_t exp_addr = '0;       // byte address of the next read

	always #50 clk = ~clk;

	determinant u_determinant (
		.i_clk (clk), .i_reset (reset),
		.i_slave_address (slave_address), .i_slave_write (slave_write),
		.i_slave_writedata (slave_writedata), .i_slave_read (slave_read),
		.o_slave_readdata (slave_readdata), .o_irq (irq),
		.o_address (mem_address), .o_read (mem_read), .i_waitrequest (mem_waitrequest),
		.i_readdata (mem_readdata), .i_readdatavalid (mem_readdatavalid)
	);

	avalon_mem_model #(.SEED (SEED)) u_mem (
		.i_clk (clk), .i_address (mem_address), .i_read (mem_read),
		.o_waitrequest (mem_waitrequest), .o_readdata (mem_readdata),
		.o_readdatavalid (mem_readdatavalid)
	);

	//////////////////////
	// slave access between two falling edges

	task automatic bus_write(input logic addr, input data_t value);
		slave_address   = addr;
		slave_writedata = value;
		slave_write     = 1'b1;
		@(negedge clk);
		slave_write = 1'b0;
	endtask

	task automatic bus_read(input logic addr, output data_t value);
		slave_address = addr;
		slave_read    = 1'b1;
		#10;                               // readdata is combinational
		value = slave_readdata;
		@(negedge clk);
		slave_read = 1'b0;
	endtask

	//////////////////////
	// compares

	task automatic check_data(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what,
			         $signed(got), $signed(exp));
			$display("TEST FAIL");
			$fatal(1, "data mismatch");
		end
	endtask

	task automatic check_status(input data_t got, input data_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_addr(input bus_addr_t got, input bus_addr_t exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "address mismatch");
		end
	endtask

	task automatic check_irq(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			$display("TEST FAIL");
			$fatal(1, "irq mismatch");
		end
	endtask

	task automatic wait_irq(input int job);
		int n;
		for (n = 0; n < TIMEOUT; n++) begin
			if (irq)
				break;
			@(negedge clk);
		end
		if (!irq) begin
			$display("timeout: irq of job %0d did not rise within %0d cycles", job, TIMEOUT);
			$display("TEST FAIL");
			$fatal(1, "irq wait expired");
		end
	endtask

	//////////////////////
	// read master monitor

	// read, address and waitrequest all hold from here to the next rising edge
	always @(negedge clk) begin
		#1;
		if (!reset && mem_read && !mem_waitrequest) begin
			check_addr(mem_address, exp_addr, "accepted read address");
			exp_addr = exp_addr + bus_addr_t'(4);   // one word per accepted read
			accepts  = accepts + 1;
		end
	end

	// fills memory row-major and returns the wrapped diagonal product
	task automatic load_matrix(input case_t c, output data_t expected);
		data_t value;
		int    n;
		int    base_word;
		n         = int'(c.size);
		base_word = int'(c.ptr >> 2);
		expected  = data_t'(1);
		for (int r = 0; r < n; r++) begin
			for (int col = 0; col < n; col++) begin
				if (r != col)
					value = $random(seed);            // off-diagonal noise
				else if (r == int'(c.zero_k))
					value = '0;
				else
					value = c.base + c.step * data_t'(r);
				if (r == col)
					expected = expected * value;      // low 32 bits match the signed product
				u_mem.write_word(base_word + r * n + col, value);
			end
		end
	endtask

	task automatic run_case(input int idx);
		data_t rd;
		data_t expected;
		load_matrix(cases[idx], expected);
		accepts  = 0;
		exp_addr = cases[idx].ptr;
		bus_write(A_PTR, data_t'(cases[idx].ptr));
		bus_write(A_SIZE, data_t'(cases[idx].size));
		bus_read(A_STATUS, rd);
		check_status(rd, BUSY, "status after size write");
		if (cases[idx].poke) begin
			bus_write(A_PTR, data_t'(32'h0000_0100));   // both must be dropped
			bus_write(A_SIZE, data_t'(7));
		end
		wait_irq(idx);
		check_data(data_t'(accepts),
		           data_t'(int'(cases[idx].size) * int'(cases[idx].size)),
		           "reads accepted");
		bus_read(A_STATUS, rd);
		check_status(rd, READY, "status after irq");
		check_irq(irq, 1'b0, "irq after one read");
		bus_read(A_RESULT, rd);
		check_data(rd, expected, "result");
		if (cases[idx].poke) begin
			for (int n = 0; n < QUIET; n++) begin
				@(negedge clk);
				check_irq(irq, 1'b0, "irq after busy writes");
			end
			bus_read(A_STATUS, rd);
			check_status(rd, READY, "status after busy writes");
		end
	endtask

	//////////////////////
	// main sequence

	initial begin
		data_t rd;
		// ptr, size, diagonal base and step, zero entry, busy writes
		cases[0] = '{30'h0000, 6'd1,  data_t'(7),  data_t'(0),  8'hff, 1'b0};
		cases[1] = '{30'h0400, 6'd2,  data_t'(-3), data_t'(5),  8'hff, 1'b0};
		cases[2] = '{30'h1000, 6'd5,  data_t'(2),  data_t'(1),  8'hff, 1'b0};
		cases[3] = '{30'h2000, 6'd32, data_t'(3),  data_t'(2),  8'hff, 1'b1};   // wraps
		cases[4] = '{30'h0800, 6'd5,  data_t'(1),  data_t'(1),  8'd3,  1'b0};   // singular
		cases[5] = '{30'h3000, 6'd32, data_t'(-1), data_t'(0),  8'hff, 1'b0};
		reset           = 1'b1;
		slave_address   = 1'b0;
		slave_write     = 1'b0;
		slave_writedata = '0;
		slave_read      = 1'b0;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_irq(irq, 1'b0, "irq after reset");
		bus_read(A_RESULT, rd);
		check_data(rd, '0, "result after reset");
		bus_read(A_STATUS, rd);
		check_status(rd, READY, "status after reset");
		for (int i = 0; i < NUM_CASES; i++)
			run_case(i);
		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire
